/* include/pat_consts.svh */
`ifndef PAT_CONSTS_SVH
`define PAT_CONSTS_SVH

// core widths
`define PAT_I_WIDTH        23
`define PAT_D_WIDTH        8
`define PAT_PC_WIDTH       10
`define PAT_REG_COUNT      8
`define PAT_REG_IDX_WIDTH  3

// escape from one opcode tier to the next
`define PAT_OPC_PREFIX     4'b1111

// ========================================
// i8 tier in instr[11:8]
`define PAT_OP_ORI         4'b0000
`define PAT_OP_ORR         4'b0001
`define PAT_OP_ANDI        4'b0010
`define PAT_OP_ANDR        4'b0011
`define PAT_OP_ADDI        4'b0100
`define PAT_OP_ADDR        4'b0101
`define PAT_OP_SUBI        4'b0110
`define PAT_OP_SUBR        4'b0111
`define PAT_OP_LDI         4'b1000
`define PAT_OP_BF          4'b1101
`define PAT_OP_CALL        4'b1110

// i3 tier in instr[7:4]
`define PAT_OP3_SHLZI      4'b0000
`define PAT_OP3_SHLZR      4'b0001
`define PAT_OP3_SHLOI      4'b0010
`define PAT_OP3_SHLOR      4'b0011
`define PAT_OP3_SHRZI      4'b0100
`define PAT_OP3_SHRZR      4'b0101
`define PAT_OP3_SHROI      4'b0110
`define PAT_OP3_SHROR      4'b0111
`define PAT_OP3_OUT        4'b1011

// i0 tier in instr[3:0]
`define PAT_OP0_NOT        4'b0000
`define PAT_OP0_TEST       4'b0010
`define PAT_OP0_RETURN     4'b0011
`define PAT_OP0_NOP        4'b0101

// flags after reset
`define PAT_RESET_Z        1'b1
`define PAT_RESET_N        1'b0

`endif

/* rtl/pat_pkg.sv */
`default_nettype none

`include "pat_consts.svh"

package pat_pkg;

	typedef logic [`PAT_I_WIDTH-1:0]       instr_t;
	typedef logic [`PAT_D_WIDTH-1:0]       data_t;
	typedef logic [`PAT_PC_WIDTH-1:0]      pc_t;
	typedef logic [`PAT_REG_IDX_WIDTH-1:0] reg_idx_t;

	// encoding matches instr[14:13]
	typedef enum logic [1:0] {
		COND_Z  = 2'd0,
		COND_NZ = 2'd1,
		COND_N  = 2'd2,
		COND_AL = 2'd3
	} cond_t;

	typedef enum logic [3:0] {
		ALU_OR,
		ALU_AND,
		ALU_ADD,
		ALU_SUB,
		ALU_NOT,
		ALU_PASS_B, // ldi
		ALU_SHLZ,
		ALU_SHLO,
		ALU_SHRZ,
		ALU_SHRO
	} alu_op_t;

	typedef enum logic {
		ST_FETCH,
		ST_EXEC
	} seq_state_t;

	typedef struct packed {
		reg_idx_t rd;
		reg_idx_t rs;
		data_t    imm;       // also the signed jump offset
		logic     use_imm;
		alu_op_t  alu_op;
		cond_t    cond;
		logic     write_reg;
		logic     out_en;
		logic     test_en;
		logic     jump;
		logic     call;
		logic     ret;
	} decoded_t;

endpackage

`default_nettype wire

/* rtl/pat_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pat_consts.svh"

module pat_decode (
	input  wire pat_pkg::instr_t i_instr,
	output pat_pkg::decoded_t    o_dec
);
	import pat_pkg::*;

	// rn in 22:20, cond in 14:13, op8 in 11:8, imm8 in 7:0
	// the rest of 19:12 is unused
	reg_idx_t rn;
	data_t imm8;
	logic [3:0] op8;
	logic [3:0] op3;
	logic [3:0] op0;
	logic tier8;
	logic tier3;

	assign rn   = i_instr[`PAT_I_WIDTH-1 -: `PAT_REG_IDX_WIDTH];
	assign op8  = i_instr[11:8];
	assign imm8 = i_instr[7:0];
	assign op3  = imm8[7:4]; // i3 opcode sits in the top of imm8
	assign op0  = imm8[3:0];

	assign tier8 = (op8 != `PAT_OPC_PREFIX);
	assign tier3 = !tier8 && (op3 != `PAT_OPC_PREFIX);

	always_comb
	begin
		o_dec         = '0;
		o_dec.rd      = rn;
		o_dec.rs      = imm8[`PAT_REG_IDX_WIDTH-1:0]; // register form reads Rimm
		o_dec.cond    = cond_t'(i_instr[14:13]);
		o_dec.alu_op  = ALU_PASS_B;
		o_dec.imm     = tier8 ? imm8 :
			{{(`PAT_D_WIDTH-`PAT_REG_IDX_WIDTH){1'b0}}, imm8[`PAT_REG_IDX_WIDTH-1:0]};

		if (tier8)
		begin
			o_dec.use_imm = ~op8[0]; // even opcode takes the immediate
			case (op8)
				`PAT_OP_ORI, `PAT_OP_ORR:   o_dec.alu_op = ALU_OR;
				`PAT_OP_ANDI, `PAT_OP_ANDR: o_dec.alu_op = ALU_AND;
				`PAT_OP_ADDI, `PAT_OP_ADDR: o_dec.alu_op = ALU_ADD;
				`PAT_OP_SUBI, `PAT_OP_SUBR: o_dec.alu_op = ALU_SUB;
				default:                    o_dec.alu_op = ALU_PASS_B;
			endcase
			o_dec.write_reg = (op8 <= `PAT_OP_LDI);
			o_dec.jump      = (op8 == `PAT_OP_BF) || (op8 == `PAT_OP_CALL);
			o_dec.call      = (op8 == `PAT_OP_CALL);
		end
		else if (tier3)
		begin
			o_dec.use_imm = ~op3[0];
			case (op3)
				`PAT_OP3_SHLZI, `PAT_OP3_SHLZR: o_dec.alu_op = ALU_SHLZ;
				`PAT_OP3_SHLOI, `PAT_OP3_SHLOR: o_dec.alu_op = ALU_SHLO;
				`PAT_OP3_SHRZI, `PAT_OP3_SHRZR: o_dec.alu_op = ALU_SHRZ;
				`PAT_OP3_SHROI, `PAT_OP3_SHROR: o_dec.alu_op = ALU_SHRO;
				default:                        o_dec.alu_op = ALU_PASS_B;
			endcase
			o_dec.write_reg = (op3 <= `PAT_OP3_SHROR);
			o_dec.out_en    = (op3 == `PAT_OP3_OUT);
		end
		else
		begin
			// nop and unknown i0 codes leave every flag low
			case (op0)
				`PAT_OP0_NOT:
				begin
					o_dec.alu_op    = ALU_NOT;
					o_dec.write_reg = 1'b1;
				end
				`PAT_OP0_TEST:   o_dec.test_en = 1'b1;
				`PAT_OP0_RETURN: o_dec.ret = 1'b1;
				default:         ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/pat_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module pat_alu (
	input  wire pat_pkg::data_t   i_a,
	input  wire pat_pkg::data_t   i_b,
	input  wire pat_pkg::alu_op_t i_op,
	output pat_pkg::data_t        o_y
);
	import pat_pkg::*;

	localparam data_t all_ones = '1;

	logic [2:0] sh_amt; // 1 to 4
	data_t fill_lo;     // ones in the bits vacated by a left shift
	data_t fill_hi;     // ones in the bits vacated by a right shift

	assign sh_amt  = {1'b0, i_b[1:0]} + 3'd1;
	assign fill_lo = ~(all_ones << sh_amt);
	assign fill_hi = ~(all_ones >> sh_amt);

	// ========================================
	// result select
	always_comb
	begin
		case (i_op)
			ALU_OR:
				o_y = i_a | i_b;
			ALU_AND:
				o_y = i_a & i_b;
			ALU_ADD:
				o_y = i_a + i_b; // wraps mod 256
			ALU_SUB:
				o_y = i_a - i_b;
			ALU_NOT:
				o_y = ~i_a;
			ALU_SHLZ:
				o_y = i_a << sh_amt;
			ALU_SHLO:
				o_y = (i_a << sh_amt) | fill_lo;
			ALU_SHRZ:
				o_y = i_a >> sh_amt;
			ALU_SHRO:
				o_y = (i_a >> sh_amt) | fill_hi;
			default:
				o_y = i_b; // pass b for ldi
		endcase
	end

endmodule

`default_nettype wire

/* rtl/pat_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pat_consts.svh"

module pat_regfile (
	input  wire logic              clk,
	input  wire pat_pkg::reg_idx_t i_rd_idx,
	input  wire pat_pkg::reg_idx_t i_rs_idx,
	input  wire logic              i_we,
	input  wire pat_pkg::data_t    i_wdata,
	output pat_pkg::data_t         o_rd_val,
	output pat_pkg::data_t         o_rs_val
);
	import pat_pkg::*;

	data_t regs [`PAT_REG_COUNT]; // contents undefined until loaded

	always_ff @(posedge clk)
	begin
		if (i_we)
			regs[i_rd_idx] <= i_wdata; // destination is always rd
	end

	// async read ports
	assign o_rd_val = regs[i_rd_idx];
	assign o_rs_val = regs[i_rs_idx];

endmodule

`default_nettype wire

/* rtl/pat_pc.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pat_consts.svh"

module pat_pc (
	input  wire logic           clk,
	input  wire logic           reset,
	input  wire logic           i_step,
	input  wire logic           i_exec_ok,
	input  wire logic           i_jump,
	input  wire logic           i_call,
	input  wire logic           i_ret,
	input  wire pat_pkg::data_t i_offset,
	output pat_pkg::pc_t        o_pc
);
	import pat_pkg::*;

	pc_t pc;
	pc_t lr;     // one call level only
	pc_t pc_inc;
	pc_t pc_rel;

	assign pc_inc = pc + 1'b1;
	assign pc_rel = pc + {{(`PAT_PC_WIDTH-`PAT_D_WIDTH){i_offset[`PAT_D_WIDTH-1]}}, i_offset};

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= '0;
			lr <= '0;
		end
		else if (i_step)
		begin
			if (i_exec_ok && i_jump)
				pc <= pc_rel; // bf and call
			else if (i_exec_ok && i_ret)
				pc <= lr;
			else
				pc <= pc_inc;
			if (i_exec_ok && i_call)
				lr <= pc_inc; // overwrites any earlier link
		end
	end

	assign o_pc = pc;

endmodule

`default_nettype wire

/* rtl/pat_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pat_consts.svh"

module pat_sequencer (
	input  wire logic              clk,
	input  wire logic              reset,
	input  wire pat_pkg::instr_t   i_wb_dat,
	input  wire logic              i_wb_ack,
	input  wire pat_pkg::decoded_t i_dec,
	input  wire pat_pkg::data_t    i_rd_val,
	output logic                   o_wb_cyc,
	output logic                   o_wb_stb,
	output pat_pkg::instr_t        o_instr,
	output logic                   o_step,
	output logic                   o_exec_ok,
	output pat_pkg::data_t         o_out,
	output logic                   o_out_valid
);
	import pat_pkg::*;

	seq_state_t state;
	logic cyc_q;    // bus request held until ack
	logic ack_edge;
	logic z;
	logic n;
	logic cond_ok;

	assign ack_edge = cyc_q && i_wb_ack;
	assign o_wb_cyc = cyc_q;
	assign o_wb_stb = cyc_q;

	always_comb
	begin
		case (i_dec.cond)
			COND_Z:  cond_ok = z;
			COND_NZ: cond_ok = ~z;
			COND_N:  cond_ok = n;
			default: cond_ok = 1'b1;
		endcase
	end

	assign o_step    = (state == ST_EXEC);
	assign o_exec_ok = o_step && cond_ok; // commit strobe

	// ========================================
	// fetch / execute control
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state       <= ST_FETCH;
			cyc_q       <= 1'b0;
			z           <= `PAT_RESET_Z;
			n           <= `PAT_RESET_N;
			o_out_valid <= 1'b0;
		end
		else
		begin
			o_out_valid <= o_exec_ok && i_dec.out_en;
			case (state)
				ST_FETCH:
				begin
					state <= ack_edge ? ST_EXEC : ST_FETCH;
					cyc_q <= !ack_edge;
				end
				default:
				begin
					state <= ST_FETCH;
					cyc_q <= 1'b1; // next fetch starts right away
					if (o_exec_ok && i_dec.test_en)
					begin
						z <= (i_rd_val == '0);
						n <= i_rd_val[`PAT_D_WIDTH-1];
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (ack_edge)
			o_instr <= i_wb_dat;
		if (o_exec_ok && i_dec.out_en)
			o_out <= i_rd_val;
	end

endmodule

`default_nettype wire

/* rtl/pat_core.sv */
`timescale 1ns/1ps
`default_nettype none

module pat_core (
	input  wire logic            clk,
	input  wire logic            reset,
	output logic                 o_wb_cyc,
	output logic                 o_wb_stb,
	output pat_pkg::pc_t         o_wb_adr,
	input  wire pat_pkg::instr_t i_wb_dat,
	input  wire logic            i_wb_ack,
	output pat_pkg::data_t       o_out,
	output logic                 o_out_valid
);
	import pat_pkg::*;

	instr_t instr;
	decoded_t dec;
	data_t rd_val;
	data_t rs_val;
	data_t alu_b;
	data_t alu_y;
	logic step;
	logic exec_ok;

	// immediate or register operand
	assign alu_b = dec.use_imm ? dec.imm : rs_val;

	pat_sequencer i_pat_sequencer (
		.clk         (clk),
		.reset       (reset),
		.i_wb_dat    (i_wb_dat),
		.i_wb_ack    (i_wb_ack),
		.i_dec       (dec),
		.i_rd_val    (rd_val),
		.o_wb_cyc    (o_wb_cyc),
		.o_wb_stb    (o_wb_stb),
		.o_instr     (instr),
		.o_step      (step),
		.o_exec_ok   (exec_ok),
		.o_out       (o_out),
		.o_out_valid (o_out_valid)
	);

	pat_decode i_pat_decode (
		.i_instr (instr),
		.o_dec   (dec)
	);

	pat_regfile i_pat_regfile (
		.clk      (clk),
		.i_rd_idx (dec.rd),
		.i_rs_idx (dec.rs),
		.i_we     (exec_ok & dec.write_reg),
		.i_wdata  (alu_y),
		.o_rd_val (rd_val),
		.o_rs_val (rs_val)
	);

	pat_alu i_pat_alu (
		.i_a  (rd_val),
		.i_b  (alu_b),
		.i_op (dec.alu_op),
		.o_y  (alu_y)
	);

	pat_pc i_pat_pc (
		.clk       (clk),
		.reset     (reset),
		.i_step    (step),
		.i_exec_ok (exec_ok),
		.i_jump    (dec.jump),
		.i_call    (dec.call),
		.i_ret     (dec.ret),
		.i_offset  (dec.imm),
		.o_pc      (o_wb_adr)
	);

endmodule

`default_nettype wire

/* verif/pat_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module pat_assert (
	input wire logic         clk,
	input wire logic         reset,
	input wire logic         i_wb_cyc,
	input wire logic         i_wb_stb,
	input wire pat_pkg::pc_t i_wb_adr,
	input wire logic         i_wb_ack,
	input wire logic         i_out_valid
);
	int fail_count = 0; // failed assertions so far

	// ========================================
	// Wishbone classic master side
	stb_needs_cyc: assert property (@(posedge clk) disable iff (reset) i_wb_stb |-> i_wb_cyc)
	else
	begin
		$error("wb stb high without cyc");
		fail_count++;
	end

	// request held steady through wait states
	req_held: assert property (@(posedge clk) disable iff (reset)
		(i_wb_stb && !i_wb_ack) |=> (i_wb_stb && $stable(i_wb_adr)))
	else
	begin
		$error("wb request changed before ack");
		fail_count++;
	end

	cyc_low_in_reset: assert property (@(posedge clk) reset |=> !i_wb_cyc)
	else
	begin
		$error("wb cyc high during reset");
		fail_count++;
	end

	// ========================================
	// output port
	out_single_pulse: assert property (@(posedge clk) disable iff (reset)
		i_out_valid |=> !i_out_valid)
	else
	begin
		$error("o_out_valid longer than one cycle");
		fail_count++;
	end

endmodule

bind pat_core pat_assert i_pat_assert (
	.clk         (clk),
	.reset       (reset),
	.i_wb_cyc    (o_wb_cyc),
	.i_wb_stb    (o_wb_stb),
	.i_wb_adr    (o_wb_adr),
	.i_wb_ack    (i_wb_ack),
	.i_out_valid (o_out_valid)
);

`default_nettype wire

/* verif/pat_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pat_consts.svh"

module pat_tb;
	import pat_pkg::*;

	localparam int NUM_INSTR      = 400;
	localparam int TIMEOUT_CYCLES = NUM_INSTR * 6 + 20;

	logic clk;
	logic reset;
	instr_t wb_dat;
	logic wb_ack;
	logic wb_cyc;
	logic wb_stb;
	pc_t wb_adr;
	data_t out_data;
	logic out_valid;

	logic [31:0] lfsr;
	int cycle_count = 0;
	int value_errors;
	int other_errors;

	// ========================================
	// reference model state
	data_t m_regs [`PAT_REG_COUNT];
	logic m_z;
	logic m_n;
	pc_t m_pc;
	pc_t m_lr;
	logic out_due; // an executed out waits for its strobe
	data_t exp_out;

	pat_core i_pat_core (
		.clk         (clk),
		.reset       (reset),
		.o_wb_cyc    (wb_cyc),
		.o_wb_stb    (wb_stb),
		.o_wb_adr    (wb_adr),
		.i_wb_dat    (wb_dat),
		.i_wb_ack    (wb_ack),
		.o_out       (out_data),
		.o_out_valid (out_valid)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("errors: %0d value, %0d other, %0d assertion", value_errors,
				other_errors, i_pat_core.i_pat_assert.fail_count);
			$display("Done: errors found");
			$finish;
		end
	end

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int count, output logic [31:0] value);
		int i;
		value = '0;
		for (i = 0; i < count; i++)
		begin
			lfsr  = lfsr_next(lfsr);
			value = {value[30:0], lfsr[0]};
		end
	endtask

	task automatic compare_pc(input string name, input pc_t expected, input pc_t actual);
		if (actual !== expected)
		begin
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic compare_data(input string name, input data_t expected, input data_t actual);
		if (actual !== expected)
		begin
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic note_failure(input string what);
		$display("%s", what);
		other_errors++;
	endtask

	// one clock, then check the output strobe against the model
	task automatic next_cycle();
		@(posedge clk);
		#1;
		if (out_due)
		begin
			if (!out_valid)
				note_failure("o_out_valid missing after an executed out");
			else
				compare_data("out value", exp_out, out_data);
			out_due = 1'b0;
		end
		else if (out_valid)
			note_failure("o_out_valid seen without an executed out");
	endtask

	task automatic make_instr(input int index, output instr_t ins);
		logic [31:0] kind;
		logic [31:0] r;
		if (index < `PAT_REG_COUNT)
		begin
			draw_bits(8, r);
			ins        = '0;
			ins[22:20] = index[2:0];
			ins[14:13] = 2'b11; // always
			ins[11:8]  = `PAT_OP_LDI;
			ins[7:0]   = r[7:0];
		end
		else
		begin
			draw_bits(3, kind);
			draw_bits(`PAT_I_WIDTH, r); // every field random including the reserved bits
			ins = r[`PAT_I_WIDTH-1:0];
			case (kind[2:0])
				3'd0, 3'd1:
				begin
					ins[11:8] = `PAT_OPC_PREFIX;
					ins[7:4]  = `PAT_OP3_OUT;
				end
				3'd2:
					ins[11:8] = `PAT_OPC_PREFIX; // i3 tier
				3'd3:
				begin
					ins[11:8] = `PAT_OPC_PREFIX;
					ins[7:4]  = `PAT_OPC_PREFIX;
					case (r[1:0])
						2'd0:    ins[3:0] = `PAT_OP0_NOT;
						2'd1:    ins[3:0] = `PAT_OP0_TEST;
						2'd2:    ins[3:0] = `PAT_OP0_RETURN;
						default: ins[3:0] = r[3:0];
					endcase
				end
				default:
					ins[11:8] = r[11:8]; // i8 tier mostly
			endcase
		end
	endtask

	task automatic model_exec(input instr_t ins);
		reg_idx_t rn;
		data_t imm8;
		data_t a;
		data_t b;
		logic [2:0] amt;
		logic [3:0] op8;
		logic [3:0] op3;
		logic run;
		pc_t next_pc;
		rn      = ins[22:20];
		imm8    = ins[7:0];
		op8     = ins[11:8];
		op3     = imm8[7:4];
		a       = m_regs[rn];
		next_pc = m_pc + pc_t'(1);
		case (ins[14:13])
			2'd0:    run = m_z;
			2'd1:    run = !m_z;
			2'd2:    run = m_n;
			default: run = 1'b1;
		endcase
		if (run && (op8 != `PAT_OPC_PREFIX))
		begin
			b = op8[0] ? m_regs[imm8[2:0]] : imm8;
			case (op8)
				`PAT_OP_ORI, `PAT_OP_ORR:   m_regs[rn] = a | b;
				`PAT_OP_ANDI, `PAT_OP_ANDR: m_regs[rn] = a & b;
				`PAT_OP_ADDI, `PAT_OP_ADDR: m_regs[rn] = a + b;
				`PAT_OP_SUBI, `PAT_OP_SUBR: m_regs[rn] = a - b;
				`PAT_OP_LDI:                m_regs[rn] = imm8;
				`PAT_OP_BF:
					next_pc = m_pc + {{(`PAT_PC_WIDTH-`PAT_D_WIDTH){imm8[7]}}, imm8};
				`PAT_OP_CALL:
				begin
					next_pc = m_pc + {{(`PAT_PC_WIDTH-`PAT_D_WIDTH){imm8[7]}}, imm8};
					m_lr    = m_pc + pc_t'(1);
				end
				default: ;
			endcase
		end
		else if (run && (op3 != `PAT_OPC_PREFIX))
		begin
			b   = op3[0] ? m_regs[imm8[2:0]] : data_t'(imm8[2:0]);
			amt = {1'b0, b[1:0]} + 3'd1;
			case (op3)
				`PAT_OP3_SHLZI, `PAT_OP3_SHLZR: m_regs[rn] = a << amt;
				`PAT_OP3_SHLOI, `PAT_OP3_SHLOR: m_regs[rn] = ~(~a << amt);
				`PAT_OP3_SHRZI, `PAT_OP3_SHRZR: m_regs[rn] = a >> amt;
				`PAT_OP3_SHROI, `PAT_OP3_SHROR: m_regs[rn] = ~(~a >> amt);
				`PAT_OP3_OUT:
				begin
					out_due = 1'b1;
					exp_out = a;
				end
				default: ;
			endcase
		end
		else if (run)
		begin
			case (imm8[3:0])
				`PAT_OP0_NOT:    m_regs[rn] = ~a;
				`PAT_OP0_TEST:
				begin
					m_z = (a == 8'h00);
					m_n = a[7];
				end
				`PAT_OP0_RETURN: next_pc = m_lr;
				default: ;
			endcase
		end
		m_pc = next_pc; // failed condition only steps the pc
	endtask

	// ========================================
	// Wishbone slave and run control
	initial
	begin
		int k;
		int assert_errors;
		instr_t ins;
		logic [31:0] waits;
		lfsr         = 32'h6c41;
		value_errors = 0;
		other_errors = 0;
		out_due      = 1'b0;
		exp_out      = '0;
		m_z          = `PAT_RESET_Z;
		m_n          = `PAT_RESET_N;
		m_pc         = '0;
		m_lr         = '0;
		reset        = 1'b1;
		wb_ack       = 1'b0;
		wb_dat       = '0;
		repeat (4)
			next_cycle();
		reset = 1'b0;

		for (k = 0; k < NUM_INSTR; k++)
		begin
			next_cycle();
			if (!wb_stb)
				note_failure("no fetch request in the cycle after reset or execute");
			while (!wb_stb)
				next_cycle();
			compare_pc("fetch address", m_pc, wb_adr);
			draw_bits(2, waits);
			repeat (waits[1:0])
				next_cycle(); // wait states
			make_instr(k, ins);
			wb_dat = ins;
			wb_ack = 1'b1;
			next_cycle(); // ack edge with the execute cycle after it
			wb_ack = 1'b0;
			wb_dat = '0;
			if (wb_stb || wb_cyc)
				note_failure("bus cycle still open in the execute cycle");
			model_exec(ins);
		end
		next_cycle(); // commit of the last instruction

		assert_errors = i_pat_core.i_pat_assert.fail_count;
		$display("errors: %0d value, %0d other, %0d assertion",
			value_errors, other_errors, assert_errors);
		if ((value_errors + other_errors + assert_errors) == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+include
rtl/pat_pkg.sv
rtl/pat_decode.sv
rtl/pat_alu.sv
rtl/pat_regfile.sv
rtl/pat_pc.sv
rtl/pat_sequencer.sv
rtl/pat_core.sv
verif/pat_assert.sv
verif/pat_tb.sv

/* Makefile */
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -Wno-fatal -Mdir obj_dir
TOP        = pat_tb
FILELIST   = src.f
SIM_ARGS   = +verilator+error+limit+1000
LOG        = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
